// File: Makefile
TOP_TB  = tbHazardUnit
TOP_RTL = hazardUnit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP_RTL)

# A $fatal in the testbench makes the binary exit non-zero
sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP_TB) -Mdir obj_dir
	./obj_dir/V$(TOP_TB)

clean:
	rm -rf obj_dir

// File: verif/tbHazardUnit.sv
`timescale 1ns/1ns
`include "hazard_config.svh"

module tbHazardUnit
    import isaPkg::*;
    import hazPkg::*;
();

    localparam int RANDOM_CYCLES = 3000;
    localparam int STALL_LIMIT   = 8;
    localparam int RESET_LIMIT   = 10;
    localparam logic [`DATA_WIDTH-1:0] DIR_BASE = 16'h0100;

    // Few bases so that computed addresses collide often
    localparam logic [`DATA_WIDTH-1:0] BASES [4] = '{16'h0100, 16'h00f8, 16'h0108, 16'hfff0};

    // Directed stream where each word is held while it stalls
    localparam logic [`DATA_WIDTH-1:0] DIRECTED [12] = '{
        16'b01000_000_001_00000,    // ALU-I writes r1
        16'b11011_001_010_011_00,   // ALU-R reads r1
        16'b10001_010_100_00011,    // LD at base+3
        16'b01010_000_010_00011,    // ALU-I with the same sum as the LD
        16'b10000_110_101_00011,    // ST at the same address
        16'b01000_000_111_00000,    // ALU-I writes r7
        16'b00101_000_000_00000,    // JR
        16'b11011_111_111_111_00,   // Wrong-path slot reading r7
        16'b00001_111_101_00000,    // Explicit NOP naming r5
        16'b01001_101_110_00000,    // ALU-I reads r5 and writes r6
        16'b01100_110_000_00001,    // Branch reads r6
        16'b10001_000_001_11111     // Wrong-path LD
    };

    logic                   clk;
    logic                   arstN;
    logic                   instrValid;
    logic [`DATA_WIDTH-1:0] instr;
    logic [`DATA_WIDTH-1:0] reg1Data;
    logic                   nop;
    logic                   pcStall;
    logic                   issueValid;

    // Reference model state
    logic [31:0]   lfsrState;
    inflightEntryT modelPipe [`INFLIGHT_DEPTH];
    logic          modelFlush;
    inflightEntryT expEntry;
    logic          expCtrl;
    logic          expNop;
    logic          expStall;
    logic          expIssue;
    logic          lastStall;

    hazardUnit hazardUnit_i (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .reg1Data   (reg1Data),
        .nop        (nop),
        .pcStall    (pcStall),
        .issueValid (issueValid)
    );

    always #4 clk = ~clk;

    initial begin
        clk   = 1'b0;
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        arstN = 1'b1;
    end

    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [15:0] drawBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[14:0], lfsrState[0]};
        end
        return v;
    endfunction

    // Weighted class table followed by eleven random field bits
    function automatic logic [`DATA_WIDTH-1:0] randomWord();
        logic [15:0] raw;
        logic [15:0] sub;
        logic [4:0]  op;
        logic [15:0] rest;
        raw = drawBits(4);
        case (raw[3:0])
            4'd0, 4'd1: op = OP_NOP;
            4'd2, 4'd3: begin
                sub = drawBits(2);
                op  = {3'b001, sub[1:0]};
            end
            4'd4, 4'd5: begin
                sub = drawBits(2);
                op  = {3'b011, sub[1:0]};
            end
            4'd6, 4'd7:   op = OP_LD;
            4'd8, 4'd9:   op = OP_ST;
            4'd10, 4'd11: op = OP_ALU_R;
            4'd12, 4'd13: begin
                sub = drawBits(2);
                op  = {3'b010, sub[1:0]};
            end
            default: begin
                sub = drawBits(5);
                op  = sub[4:0];
            end
        endcase
        rest = drawBits(11);
        return {op, rest[10:0]};
    endfunction

    task automatic checkVerdict(
        input string name,
        input logic  eNop,
        input logic  eStall,
        input logic  eIssue,
        input logic  aNop,
        input logic  aStall,
        input logic  aIssue
    );
        if ({aNop, aStall, aIssue} !== {eNop, eStall, eIssue}) begin
            stopOnError($sformatf("MISMATCH %s nop,pcStall,issueValid expected %b%b%b actual %b%b%b",
                name, eNop, eStall, eIssue, aNop, aStall, aIssue));
        end
    endtask

    task automatic checkIdle(
        input string name,
        input logic  aNop,
        input logic  aStall,
        input logic  aIssue
    );
        if ({aNop, aStall, aIssue} !== 3'b000) begin
            stopOnError($sformatf("MISMATCH %s idle outputs expected 000 actual %b%b%b",
                name, aNop, aStall, aIssue));
        end
    endtask

    task automatic predictVerdict(
        input logic                   v,
        input instrWordU              w,
        input logic [`DATA_WIDTH-1:0] base
    );
        logic [4:0] op;
        logic       isNopI;
        logic       readsRt;
        logic       isAluR;
        logic       regHit;
        logic       memHit;
        op      = w.rFmt.opcode;
        isNopI  = (op == OP_NOP);
        isAluR  = (op == OP_ALU_R);
        readsRt = isAluR || (op == OP_ST);
        expCtrl = (op[4:2] == 3'b001) || (op[4:2] == 3'b011);
        expEntry.valid     = 1'b1;
        expEntry.writesReg = isAluR || (op == OP_LD) || (op[4:2] == 3'b010);
        expEntry.rd        = isAluR ? w.rFmt.rd : w.iFmt.rd;
        expEntry.isMem     = (op == OP_LD) || (op == OP_ST);
        expEntry.memAddr   = base + {{(`DATA_WIDTH-5){w.iFmt.imm5[4]}}, w.iFmt.imm5};
        regHit = 1'b0;
        memHit = 1'b0;
        for (int i = 0; i < `INFLIGHT_DEPTH; i++) begin
            if (modelPipe[i].valid && modelPipe[i].writesReg && !isNopI) begin
                if (modelPipe[i].rd == w.rFmt.rs || (readsRt && modelPipe[i].rd == w.rFmt.rt)) begin
                    regHit = 1'b1;
                end
            end
            if (modelPipe[i].valid && modelPipe[i].isMem && expEntry.isMem &&
                modelPipe[i].memAddr == expEntry.memAddr) begin
                memHit = 1'b1;
            end
        end
        expNop   = 1'b0;
        expStall = 1'b0;
        expIssue = 1'b0;
        if (v) begin
            if (modelFlush) begin
                expNop = 1'b1;
            end else if (regHit || memHit) begin
                expNop   = 1'b1;
                expStall = 1'b1;
            end else if (isNopI) begin
                expNop = 1'b1;
            end else begin
                expIssue = 1'b1;
            end
        end
    endtask

    task automatic advanceModel();
        for (int i = `INFLIGHT_DEPTH - 1; i > 0; i--) begin
            modelPipe[i] = modelPipe[i-1];
        end
        if (expIssue) begin
            modelPipe[0] = expEntry;
        end else begin
            modelPipe[0] = '0;
        end
        modelFlush = expIssue && expCtrl;
        lastStall  = expStall;
    endtask

    task automatic runCycle(
        input string                  name,
        input logic                   v,
        input logic [`DATA_WIDTH-1:0] word,
        input logic [`DATA_WIDTH-1:0] base
    );
        @(posedge clk);
        #1;
        instrValid = v;
        instr      = word;
        reg1Data   = base;
        predictVerdict(v, instrWordU'(word), base);
        // Sample mid-cycle well clear of both edges
        #4;
        if (v) begin
            checkVerdict(name, expNop, expStall, expIssue, nop, pcStall, issueValid);
        end else begin
            checkIdle(name, nop, pcStall, issueValid);
        end
        advanceModel();
    endtask

    task automatic presentWord(input string name, input logic [`DATA_WIDTH-1:0] word);
        int tries;
        tries = 0;
        runCycle(name, 1'b1, word, DIR_BASE);
        while (lastStall) begin
            tries++;
            if (tries > STALL_LIMIT) begin
                stopOnError($sformatf("%s stayed stalled after the pipe should have drained", name));
            end
            runCycle(name, 1'b1, word, DIR_BASE);
        end
    endtask

    initial begin
        int                     waitCycles;
        int                     holdCount;
        logic [15:0]            raw;
        logic                   curValid;
        logic [`DATA_WIDTH-1:0] curWord;
        logic [`DATA_WIDTH-1:0] curBase;
        instrValid = 1'b0;
        instr      = '0;
        reg1Data   = '0;
        lfsrState  = 32'h62b6;
        lastStall  = 1'b0;
        modelFlush = 1'b0;
        for (int i = 0; i < `INFLIGHT_DEPTH; i++) begin
            modelPipe[i] = '0;
        end
        waitCycles = 0;
        while (arstN !== 1'b1) begin
            @(posedge clk);
            waitCycles++;
            if (waitCycles > RESET_LIMIT) begin
                stopOnError("reset was never released");
            end
        end

        runCycle("idle after reset", 1'b0, '0, '0);
        runCycle("idle after reset", 1'b0, '0, '0);
        for (int k = 0; k < 12; k++) begin
            presentWord($sformatf("directed %0d", k), DIRECTED[k]);
        end

        // Stalled words are presented again unchanged
        curValid  = 1'b0;
        curWord   = '0;
        curBase   = '0;
        holdCount = 0;
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            if (lastStall) begin
                holdCount++;
                if (holdCount > STALL_LIMIT) begin
                    stopOnError("random stream stayed stalled after the pipe should have drained");
                end
            end else begin
                holdCount = 0;
                raw       = drawBits(4);
                curValid  = raw[3:0] < 4'd13;
                curWord   = randomWord();
                raw       = drawBits(2);
                curBase   = BASES[raw[1:0]];
            end
            runCycle($sformatf("random cycle %0d", c), curValid, curWord, curBase);
        end

        $display("sim passed");
        $finish;
    end

endmodule

// File: verilog/decodedIf.sv
`timescale 1ns/1ns
`include "hazard_config.svh"

interface decodedIf;
    logic                       valid;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic                       usesRt;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic                       writesReg;
    logic                       isMem;
    logic [`DATA_WIDTH-1:0]     memAddr;
    logic                       isCtrl;
    logic                       isNop;

    modport source (
        output valid, rs, rt, usesRt, rd, writesReg, isMem, memAddr, isCtrl, isNop
    );

    // Hazard checker sees the whole bundle
    modport check (
        input valid, rs, rt, usesRt, rd, writesReg, isMem, memAddr, isCtrl, isNop
    );

    modport control (
        input valid, isCtrl, isNop
    );
endinterface

// File: verilog/hazPkg.sv
`include "hazard_config.svh"

package hazPkg;

    // One tracked instruction in ID, EX, MEM or WB
    typedef struct packed {
        logic                       valid;
        logic                       writesReg;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic                       isMem;
        logic [`DATA_WIDTH-1:0]     memAddr;
    } inflightEntryT;

    // Empty slot shifted in when nothing issues
    localparam inflightEntryT BUBBLE = '0;

endpackage

// File: verilog/hazardCheck.sv
`timescale 1ns/1ns
`include "hazard_config.svh"

module hazardCheck
    import hazPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    decodedIf.check  dec,
    input  logic     issue,
    output logic     regHaz,
    output logic     memHaz
);

    // Index 0 is ID and the last index is WB
    inflightEntryT pipe [`INFLIGHT_DEPTH];
    inflightEntryT newEntry;
    logic          regHit;
    logic          memHit;

    always_comb begin
        newEntry.valid     = 1'b1;
        newEntry.writesReg = dec.writesReg;
        newEntry.rd        = dec.rd;
        newEntry.isMem     = dec.isMem;
        newEntry.memAddr   = dec.memAddr;
    end

    // Pipe shifts every cycle and takes a bubble when nothing issues
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `INFLIGHT_DEPTH; i++) begin
                pipe[i] <= BUBBLE;
            end
        end else begin
            pipe[0] <= issue ? newEntry : BUBBLE;
            for (int i = 1; i < `INFLIGHT_DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    // Compare the new instruction against every tracked stage
    always_comb begin
        regHit = 1'b0;
        memHit = 1'b0;
        for (int i = 0; i < `INFLIGHT_DEPTH; i++) begin
            if (pipe[i].valid && pipe[i].writesReg) begin
                if (pipe[i].rd == dec.rs) begin
                    regHit = 1'b1;
                end
                if (dec.usesRt && (pipe[i].rd == dec.rt)) begin
                    regHit = 1'b1;
                end
            end
            if (pipe[i].valid && pipe[i].isMem && (pipe[i].memAddr == dec.memAddr)) begin
                memHit = 1'b1;
            end
        end
    end

    // An explicit NOP reads nothing
    assign regHaz = dec.valid && !dec.isNop && regHit;
    assign memHaz = dec.valid && dec.isMem && memHit;

endmodule

// File: verilog/hazardUnit.sv
`timescale 1ns/1ns
`include "hazard_config.svh"

module hazardUnit
    import isaPkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   instrValid,
    input  logic [`DATA_WIDTH-1:0] instr,
    input  logic [`DATA_WIDTH-1:0] reg1Data,
    output logic                   nop,
    output logic                   pcStall,
    output logic                   issueValid
);

    logic regHaz;
    logic memHaz;

    decodedIf decBus ();

    instrDecode instrDecode_i (
        .instrValid (instrValid),
        .instr      (instrWordU'(instr)),
        .reg1Data   (reg1Data),
        .dec        (decBus)
    );

    // issueValid also decides what enters the pipe
    hazardCheck hazardCheck_i (
        .clk    (clk),
        .arstN  (arstN),
        .dec    (decBus),
        .issue  (issueValid),
        .regHaz (regHaz),
        .memHaz (memHaz)
    );

    issueControl issueControl_i (
        .clk     (clk),
        .arstN   (arstN),
        .dec     (decBus),
        .regHaz  (regHaz),
        .memHaz  (memHaz),
        .issue   (issueValid),
        .nop     (nop),
        .pcStall (pcStall)
    );

endmodule

// File: verilog/hazard_config.svh
`ifndef HAZARD_CONFIG_SVH
`define HAZARD_CONFIG_SVH

// Instruction and data word width
`define DATA_WIDTH 16

// Eight architectural registers
`define REG_ADDR_WIDTH 3

// Tracked stages ID, EX, MEM and WB
`define INFLIGHT_DEPTH 4

`endif

// File: verilog/instrDecode.sv
`timescale 1ns/1ns
`include "hazard_config.svh"

module instrDecode
    import isaPkg::*;
(
    input  logic                   instrValid,
    input  instrWordU              instr,
    input  logic [`DATA_WIDTH-1:0] reg1Data,
    decodedIf.source               dec
);

    instrClassE             cls;
    logic [4:0]             opcode;
    logic [`DATA_WIDTH-1:0] immExt;

    assign opcode = instr.rFmt.opcode;

    // Exact opcodes take priority over groups
    always_comb begin
        if (opcode == OP_NOP) begin
            cls = clsNop;
        end else if (opcode == OP_LD) begin
            cls = clsLoad;
        end else if (opcode == OP_ST) begin
            cls = clsStore;
        end else if (opcode == OP_ALU_R) begin
            cls = clsAluR;
        end else if (opcode[4:2] == OP_JUMP_GRP) begin
            cls = clsJump;
        end else if (opcode[4:2] == OP_BRANCH_GRP) begin
            cls = clsBranch;
        end else if (opcode[4:2] == OP_ALUI_GRP) begin
            cls = clsAluI;
        end else begin
            cls = clsOther;
        end
    end

    // Base plus sign-extended offset
    assign immExt = {{(`DATA_WIDTH-5){instr.iFmt.imm5[4]}}, instr.iFmt.imm5};

    assign dec.valid   = instrValid;
    assign dec.rs      = instr.rFmt.rs;
    assign dec.rt      = instr.rFmt.rt;
    assign dec.usesRt  = (cls == clsAluR) || (cls == clsStore);
    assign dec.memAddr = reg1Data + immExt;

    // Destination slot depends on format
    always_comb begin
        if (cls == clsAluR) begin
            dec.rd = instr.rFmt.rd;
        end else begin
            dec.rd = instr.iFmt.rd;
        end
    end

    assign dec.writesReg = (cls == clsAluR) || (cls == clsLoad) || (cls == clsAluI);
    assign dec.isMem     = (cls == clsLoad) || (cls == clsStore);
    assign dec.isCtrl    = (cls == clsJump) || (cls == clsBranch);
    assign dec.isNop     = (cls == clsNop);

endmodule

// File: verilog/isaPkg.sv
`include "hazard_config.svh"

package isaPkg;

    // Register-format layout
    typedef struct packed {
        logic [4:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [1:0]                 func;
    } rFmtT;

    // Immediate-format layout with rd in the rt slot
    typedef struct packed {
        logic [4:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [4:0]                 imm5;
    } iFmtT;

    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
    } instrWordU;

    localparam logic [4:0] OP_NOP   = 5'b00001;
    localparam logic [4:0] OP_ST    = 5'b10000;
    localparam logic [4:0] OP_LD    = 5'b10001;
    localparam logic [4:0] OP_ALU_R = 5'b11011;

    // Groups matched on opcode[4:2]
    // JR forms sit inside the jump group
    localparam logic [2:0] OP_JUMP_GRP   = 3'b001;
    localparam logic [2:0] OP_ALUI_GRP   = 3'b010;
    localparam logic [2:0] OP_BRANCH_GRP = 3'b011;

    typedef enum logic [2:0] {
        clsNop,
        clsJump,
        clsBranch,
        clsLoad,
        clsStore,
        clsAluR,
        clsAluI,
        clsOther
    } instrClassE;

endpackage

// File: verilog/issueControl.sv
`timescale 1ns/1ns

module issueControl (
    input  logic      clk,
    input  logic      arstN,
    decodedIf.control dec,
    input  logic      regHaz,
    input  logic      memHaz,
    output logic      issue,
    output logic      nop,
    output logic      pcStall
);

    logic flushQ;

    // Squash exactly one slot after a jump or branch issues
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flushQ <= 1'b0;
        end else begin
            flushQ <= issue && dec.isCtrl;
        end
    end

    // Flush beats hazard, hazard beats explicit NOP
    always_comb begin
        issue   = 1'b0;
        nop     = 1'b0;
        pcStall = 1'b0;
        if (dec.valid) begin
            if (flushQ) begin
                nop = 1'b1;
            end else if (regHaz || memHaz) begin
                nop     = 1'b1;
                pcStall = 1'b1;
            end else if (dec.isNop) begin
                nop = 1'b1;
            end else begin
                issue = 1'b1;
            end
        end
    end

endmodule

// File: vlog.f
+incdir+verilog
verilog/isaPkg.sv
verilog/hazPkg.sv
verilog/decodedIf.sv
verilog/instrDecode.sv
verilog/hazardCheck.sv
verilog/issueControl.sv
verilog/hazardUnit.sv
verif/tbHazardUnit.sv
